//--- Bender.yml
package:
  name: tenyr

sources:
  - tenyr_pkg.sv
  - tenyr_regfile.sv
  - tenyr_decode.sv
  - tenyr_alu.sv
  - tenyr_wb_master.sv
  - tenyr_core.sv
  - tenyr_top.sv
  - target: test
    files:
      - tb_tenyr_clkgen.sv
      - tb_tenyr.sv

//--- tenyr.f
tenyr_pkg.sv
tenyr_regfile.sv
tenyr_decode.sv
tenyr_alu.sv
tenyr_wb_master.sv
tenyr_core.sv
tenyr_top.sv
tb_tenyr_clkgen.sv
tb_tenyr.sv

//--- tb_tenyr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr;
    import tenyr_pkg::*;

    logic  clk, reset_n;
    logic  wb_cyc, wb_stb, wb_we, wb_ack, halt;
    word_t wb_adr, wb_dat, wb_rdata;

    word_t mem [0:1023];     // Bus side memory
    word_t ref_mem [0:1023]; // Model copy
    word_t ref_regs [0:15];
    word_t ref_pc;
    word_t wp;               // Program write pointer
    int    ack_delay [0:255];
    logic  txn_we [$];
    word_t txn_adr [$];
    word_t txn_dat [$];
    int    value_errors, other_errors, cycles, timeout_limit, prog_len;
    int    txn_count, wait_left;
    logic  pending, cyc_after_halt;

    tb_tenyr_clkgen i_clkgen (.o_clk(clk), .o_reset_n(reset_n));

    tenyr_top i_tenyr_top (
        .i_clk(clk), .i_reset_n(reset_n),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we),
        .o_wb_adr(wb_adr), .o_wb_dat(wb_dat),
        .i_wb_dat(wb_rdata), .i_wb_ack(wb_ack), .o_halt(halt)
    );

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0d ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic word_t make_op(logic typ, deref_t d, reg_idx_t z, reg_idx_t x,
                                      reg_idx_t y, opcode_t op, imm_t imm);
        insn_t w;
        w.op.kind     = 1'b0;
        w.op.type_bit = typ;
        w.op.deref    = d;
        w.op.z        = z;
        w.op.x        = x;
        w.op.y        = y;
        w.op.op       = op;
        w.op.imm      = imm;
        return w;
    endfunction

    function automatic void place_word(word_t w);
        mem[wp[9:0]]     = w;
        ref_mem[wp[9:0]] = w;
        wp++;
    endfunction

    // Register read as the ISA sees it
    function automatic word_t reg_value(reg_idx_t idx, word_t next);
        if (idx == 4'd0) return '0;
        if (idx == REG_PC) return next;
        return ref_regs[idx];
    endfunction

    function automatic word_t ref_base(opcode_t op, word_t x, word_t o);
        case (op)
            OP_OR:    return x | o;
            OP_AND:   return x & o;
            OP_ADD:   return x + o;
            OP_MUL:   return x * o;
            OP_SHL:   return (o > 32'd31) ? '0 : x << o[4:0];
            OP_CMPLE: return ($signed(x) <= $signed(o)) ? 32'd1 : 32'd0;
            OP_CMPEQ: return (x == o) ? 32'd1 : 32'd0;
            OP_NOR:   return ~(x | o);
            OP_NAND:  return ~(x & o);
            OP_XOR:   return x ^ o;
            OP_SUB:   return x - o;
            OP_XORN:  return x ^ ~o;
            OP_SHR:   return (o > 32'd31) ? '0 : x >> o[4:0];
            OP_CMPGT: return ($signed(x) > $signed(o)) ? 32'd1 : 32'd0;
            OP_CMPNE: return (x != o) ? 32'd1 : 32'd0;
            default:  return '0; // Reserved op keeps the addend only
        endcase
    endfunction

    // One model instruction and the data access it should cause
    function automatic void ref_step(output logic acc, output logic we, output word_t adr,
                                     output word_t dat, output logic stop);
        insn_t ins;
        word_t next, xv, yv, zv, imm_x, ov, av, rhs, new_pc;
        ins    = ref_mem[ref_pc[9:0]];
        next   = ref_pc + 32'd1;
        new_pc = next;
        acc    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat    = '0;
        stop   = 1'b0;
        if (ins.trap.marker == TRAP_MARKER) begin
            stop   = 1'b1;
            new_pc = ref_pc;
        end else if (!ins.op.kind) begin
            xv    = reg_value(ins.op.x, next);
            yv    = reg_value(ins.op.y, next);
            zv    = reg_value(ins.op.z, next);
            imm_x = {{20{ins.op.imm[11]}}, ins.op.imm};
            ov    = ins.op.type_bit ? imm_x : yv;
            av    = ins.op.type_bit ? yv : imm_x;
            rhs   = ref_base(ins.op.op, xv, ov) + av;
            acc   = (ins.op.deref != DEREF_NONE);
            case (ins.op.deref)
                DEREF_NONE: dat = rhs;
                DEREF_LOAD: begin
                    adr = rhs;
                    dat = ref_mem[rhs[9:0]];
                end
                DEREF_STZ: begin
                    we  = 1'b1;
                    adr = zv;
                    dat = rhs;
                end
                default: begin
                    we  = 1'b1;
                    adr = rhs;
                    dat = zv;
                end
            endcase
            if (we) ref_mem[adr[9:0]] = dat;
            if (!acc || ins.op.deref == DEREF_LOAD) begin
                if (ins.op.z == REG_PC) new_pc = dat; // Jump
                else if (ins.op.z != 4'd0) ref_regs[ins.op.z] = dat;
            end
            if (!acc) dat = '0;
        end
        ref_pc = new_pc;
    endfunction

    task automatic pop_bus_cycle(output logic we, output word_t adr, output word_t dat);
        while (txn_adr.size() == 0) @(negedge clk);
        we  = txn_we.pop_front();
        adr = txn_adr.pop_front();
        dat = txn_dat.pop_front();
    endtask

    initial begin : setup
        int       seed, rnd;
        word_t    dptr;
        reg_idx_t z, x, y;
        imm_t     imm;
        logic [4:0] sel;
        wb_ack         = 1'b0;
        wb_rdata       = '0;
        value_errors   = 0;
        other_errors   = 0;
        cycles         = 0;
        txn_count      = 0;
        wait_left      = 0;
        pending        = 1'b0;
        cyc_after_halt = 1'b0;
        seed = 80;
        rnd  = $urandom(seed);
        for (int a = 0; a < 1024; a++) begin
            mem[a]     = {~a[15:0], a[15:0]} ^ 32'h5A5A_0000;
            ref_mem[a] = mem[a];
        end
        for (int r = 0; r < 16; r++) ref_regs[r] = '0;
        for (int d = 0; d < 256; d++) ack_delay[d] = $urandom % 4;
        ref_pc = RESET_VECTOR;
        wp     = RESET_VECTOR;
        dptr   = 32'h200;
        // 32 operations cover every opcode with both type bits
        for (int i = 0; i < 32; i++) begin
            sel = i[4:0];
            rnd = $urandom % 14;
            z   = rnd[3:0] + 4'd1;
            rnd = $urandom;
            x   = rnd[3:0];
            y   = rnd[7:4];
            imm = rnd[19:8];
            place_word(make_op(sel[4], DEREF_NONE, z, x, y, opcode_t'(sel[3:0]), imm));
            place_word(make_op(1'b0, DEREF_STRHS, z, 4'd0, 4'd0, OP_OR, dptr[11:0]));
            dptr++;
        end
        place_word(make_op(1'b0, DEREF_LOAD, 4'd3, 4'd0, 4'd0, OP_OR, 12'h200));
        place_word(make_op(1'b0, DEREF_STRHS, 4'd3, 4'd0, 4'd0, OP_OR, dptr[11:0]));
        dptr++;
        place_word(make_op(1'b1, DEREF_NONE, 4'd0, 4'd5, 4'd0, OP_ADD, 12'h7A5));
        place_word(make_op(1'b0, DEREF_STRHS, 4'd0, 4'd0, 4'd0, OP_OR, dptr[11:0]));
        place_word(make_op(1'b1, DEREF_NONE, REG_PC, REG_PC, 4'd0, OP_ADD, 12'd1));
        place_word(32'hF0BA_D000); // Skipped by the jump
        place_word(32'h8000_1234); // No-op
        place_word(32'hF000_0000); // Trap
        prog_len      = wp - RESET_VECTOR;
        timeout_limit = prog_len * 3 * 6 + 50;
    end

    // Wishbone slave memory with random wait states
    always @(negedge clk) begin : bus_memory
        if (halt && wb_cyc) cyc_after_halt = 1'b1;
        if (!reset_n) begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
            check_flag("o_wb_cyc", wb_cyc, 1'b0); // Both drop in the cycle after ack
            check_flag("o_wb_stb", wb_stb, 1'b0);
        end else if (wb_cyc) begin
            check_flag("o_wb_stb", wb_stb, 1'b1);
            if (!pending) begin
                pending   = 1'b1;
                wait_left = ack_delay[txn_count % 256];
            end
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                if (wb_adr > 32'd1023) begin
                    other_errors++;
                    $display("Bus address %h at %0d ns is outside the memory", wb_adr, $time);
                end
                if (wb_we) mem[wb_adr[9:0]] = wb_dat;
                wb_rdata = mem[wb_adr[9:0]];
                txn_we.push_back(wb_we);
                txn_adr.push_back(wb_adr);
                txn_dat.push_back(wb_we ? wb_dat : wb_rdata);
                wb_ack  = 1'b1;
                pending = 1'b0;
                txn_count++;
            end
        end
    end

    initial begin : compare
        logic  we, exp_we, acc, stop;
        word_t adr, dat, exp_adr, exp_dat, exp_fetch;
        stop = 1'b0;
        wait (reset_n === 1'b1);
        while (!stop) begin
            exp_fetch = ref_pc;
            pop_bus_cycle(we, adr, dat);
            check_flag("o_wb_we", we, 1'b0);
            check_word("o_wb_adr", adr, exp_fetch);
            check_flag("o_halt", halt, 1'b0);
            ref_step(acc, exp_we, exp_adr, exp_dat, stop);
            if (acc) begin
                pop_bus_cycle(we, adr, dat);
                check_flag("o_wb_we", we, exp_we);
                check_word("o_wb_adr", adr, exp_adr);
                if (exp_we) check_word("o_wb_dat", dat, exp_dat);
            end
        end
        while (halt !== 1'b1) @(negedge clk);
        repeat (20) @(negedge clk);
        check_flag("o_halt", halt, 1'b1); // Still parked
        if (cyc_after_halt || txn_adr.size() != 0) begin
            other_errors++;
            $display("A bus cycle started after the trap word");
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            other_errors++;
            $display("Timeout: the program did not finish within %0d cycles", timeout_limit);
            $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb_tenyr_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr_clkgen (
    output logic o_clk,
    output logic o_reset_n
);
    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk; // 100 ns period
    end

    // Two full cycles in reset, released on a falling edge
    initial begin
        o_reset_n = 1'b0;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_reset_n = 1'b1;
    end
endmodule

`default_nettype wire

//--- tenyr_top.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_top (
    input  wire              i_clk,
    input  wire              i_reset_n,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output logic             o_wb_we,
    output tenyr_pkg::word_t o_wb_adr,
    output tenyr_pkg::word_t o_wb_dat,
    input  tenyr_pkg::word_t i_wb_dat,
    input  wire              i_wb_ack,
    output logic             o_halt
);
    import tenyr_pkg::*;

    // Core to bus master
    logic  bus_req, bus_we, bus_done;
    word_t bus_adr, bus_dat, bus_rdata;

    tenyr_core u_core (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_bus_done(bus_done), .i_bus_rdata(bus_rdata),
        .o_bus_req(bus_req), .o_bus_we(bus_we),
        .o_bus_adr(bus_adr), .o_bus_dat(bus_dat),
        .o_halt(o_halt)
    );

    tenyr_wb_master u_wb_master (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_req(bus_req), .i_we(bus_we), .i_adr(bus_adr), .i_dat(bus_dat),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack),
        .o_done(bus_done), .o_rdata(bus_rdata),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
        .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat)
    );

endmodule

`default_nettype wire

//--- tenyr_core.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_core (
    input  wire              i_clk,
    input  wire              i_reset_n,
    input  wire              i_bus_done,
    input  tenyr_pkg::word_t i_bus_rdata,
    output logic             o_bus_req,
    output logic             o_bus_we,
    output tenyr_pkg::word_t o_bus_adr,
    output tenyr_pkg::word_t o_bus_dat,
    output logic             o_halt
);
    import tenyr_pkg::*;

    logic [2:0] state_q;
    logic       waiting_q; // Bus request outstanding
    word_t      pc_q;
    word_t      next_pc;
    insn_t      insn_q;
    word_t      rhs_q;

    reg_idx_t dec_z, dec_x, dec_y;
    imm_t     dec_imm;
    opcode_t  dec_op;
    deref_t   dec_deref;
    logic     dec_type, dec_is_op, dec_is_trap;

    reg_idx_t rd_x_idx;
    word_t    rd_x, rd_y, rhs, z_val;
    logic     wr_en;
    word_t    wr_data;

    assign next_pc  = pc_q + 32'd1;
    assign rd_x_idx = (state_q == CORE_MEM) ? dec_z : dec_x; // X port reads Z in MEM
    assign z_val    = rd_x;

    // Plain operations write in EXEC, loads in WB
    assign wr_en = (state_q == CORE_EXEC && dec_is_op && dec_deref == DEREF_NONE &&
                    dec_z != REG_PC) ||
                   (state_q == CORE_WB && dec_z != REG_PC);
    assign wr_data = (state_q == CORE_WB) ? i_bus_rdata : rhs;

    assign o_bus_req = (state_q == CORE_FETCH || state_q == CORE_MEM) && !waiting_q;
    assign o_bus_we  = (state_q == CORE_MEM) && dec_deref[1];
    assign o_bus_adr = (state_q == CORE_FETCH) ? pc_q :
                       dec_deref[0] ? rhs_q : z_val;
    assign o_bus_dat = dec_deref[0] ? z_val : rhs_q;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q   <= CORE_FETCH;
            waiting_q <= 1'b0;
            pc_q      <= RESET_VECTOR;
            o_halt    <= 1'b0;
        end else begin
            if (o_bus_req) begin
                waiting_q <= 1'b1;
            end else if (i_bus_done) begin
                waiting_q <= 1'b0;
            end
            case (state_q)
                CORE_FETCH: if (i_bus_done) state_q <= CORE_EXEC;
                CORE_EXEC: begin
                    if (dec_is_trap) begin
                        o_halt  <= 1'b1;
                        state_q <= CORE_HALT;
                    end else if (!dec_is_op) begin
                        pc_q    <= next_pc; // No-op
                        state_q <= CORE_FETCH;
                    end else if (dec_deref == DEREF_NONE) begin
                        pc_q    <= (dec_z == REG_PC) ? rhs : next_pc;
                        state_q <= CORE_FETCH;
                    end else begin
                        state_q <= CORE_MEM;
                    end
                end
                CORE_MEM: begin
                    if (i_bus_done) begin
                        if (dec_deref == DEREF_LOAD) begin
                            state_q <= CORE_WB;
                        end else begin
                            pc_q    <= next_pc;
                            state_q <= CORE_FETCH;
                        end
                    end
                end
                CORE_WB: begin
                    pc_q    <= (dec_z == REG_PC) ? i_bus_rdata : next_pc; // Load into PC jumps
                    state_q <= CORE_FETCH;
                end
                default: state_q <= CORE_HALT; // Parked until reset
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == CORE_FETCH && i_bus_done) insn_q <= i_bus_rdata;
        if (state_q == CORE_EXEC) rhs_q <= rhs;
    end

    tenyr_regfile u_regfile (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_rd_x_idx(rd_x_idx), .i_rd_y_idx(dec_y),
        .i_wr_en(wr_en), .i_wr_idx(dec_z), .i_wr_data(wr_data),
        .i_next_pc(next_pc), .o_rd_x(rd_x), .o_rd_y(rd_y)
    );

    tenyr_decode u_decode (
        .i_insn(insn_q), .o_z(dec_z), .o_x(dec_x), .o_y(dec_y), .o_imm(dec_imm),
        .o_op(dec_op), .o_deref(dec_deref), .o_type(dec_type),
        .o_is_op(dec_is_op), .o_is_trap(dec_is_trap)
    );

    tenyr_alu u_alu (
        .i_x(rd_x), .i_y(rd_y), .i_imm(dec_imm), .i_op(dec_op),
        .i_type(dec_type), .o_rhs(rhs)
    );

    a_halt_sticky: assert property (@(posedge i_clk) o_halt && i_reset_n |=> o_halt);

    a_no_req_halted: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_halt |-> !o_bus_req
    );

endmodule

`default_nettype wire

//--- tenyr_wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_wb_master (
    input  wire              i_clk,
    input  wire              i_reset_n,
    input  wire              i_req,
    input  wire              i_we,
    input  tenyr_pkg::word_t i_adr,
    input  tenyr_pkg::word_t i_dat,
    input  tenyr_pkg::word_t i_wb_dat,
    input  wire              i_wb_ack,
    output logic             o_done,
    output tenyr_pkg::word_t o_rdata,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output logic             o_wb_we,
    output tenyr_pkg::word_t o_wb_adr,
    output tenyr_pkg::word_t o_wb_dat
);
    logic ack_seen;

    assign ack_seen = o_wb_cyc && i_wb_ack;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_done <= ack_seen; // One-cycle pulse after ack
            if (ack_seen) begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_we  <= 1'b0;
            end else if (i_req && !o_wb_cyc) begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                o_wb_we  <= i_we;
            end
        end
    end

    // Bus payload and read capture
    always_ff @(posedge i_clk) begin
        if (i_req && !o_wb_cyc) begin
            o_wb_adr <= i_adr;
            o_wb_dat <= i_dat;
        end
        if (ack_seen) begin
            o_rdata <= i_wb_dat; // Held until the next ack
        end
    end

    a_stb_in_cyc: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_wb_stb |-> o_wb_cyc
    );

    a_adr_stable: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_wb_stb && !i_wb_ack |=> $stable(o_wb_adr)
    );

endmodule

`default_nettype wire

//--- tenyr_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_alu (
    input  tenyr_pkg::word_t   i_x,
    input  tenyr_pkg::word_t   i_y,
    input  tenyr_pkg::imm_t    i_imm,
    input  tenyr_pkg::opcode_t i_op,
    input  wire                i_type,
    output tenyr_pkg::word_t   o_rhs
);
    import tenyr_pkg::*;

    word_t imm_ext;
    word_t o_val; // Second operand
    word_t a_val; // Addend
    word_t base;

    assign imm_ext = {{20{i_imm[11]}}, i_imm};

    // Type bit swaps the roles of Y and the immediate
    assign o_val = i_type ? imm_ext : i_y;
    assign a_val = i_type ? i_y : imm_ext;

    always_comb begin
        case (i_op)
            OP_OR:    base = i_x | o_val;
            OP_AND:   base = i_x & o_val;
            OP_ADD:   base = i_x + o_val;
            OP_MUL:   base = i_x * o_val;
            OP_RSVD:  base = '0;
            OP_SHL:   base = i_x << o_val; // Full-width shift amount
            OP_CMPLE: base = {31'b0, $signed(i_x) <= $signed(o_val)};
            OP_CMPEQ: base = {31'b0, i_x == o_val};
            OP_NOR:   base = ~(i_x | o_val);
            OP_NAND:  base = ~(i_x & o_val);
            OP_XOR:   base = i_x ^ o_val;
            OP_SUB:   base = i_x - o_val;
            OP_XORN:  base = i_x ^ ~o_val;
            OP_SHR:   base = i_x >> o_val;
            OP_CMPGT: base = {31'b0, $signed(i_x) > $signed(o_val)};
            OP_CMPNE: base = {31'b0, i_x != o_val};
            default:  base = '0;
        endcase
    end

    assign o_rhs = base + a_val;

endmodule

`default_nettype wire

//--- tenyr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_decode (
    input  tenyr_pkg::insn_t    i_insn,
    output tenyr_pkg::reg_idx_t o_z,
    output tenyr_pkg::reg_idx_t o_x,
    output tenyr_pkg::reg_idx_t o_y,
    output tenyr_pkg::imm_t     o_imm,
    output tenyr_pkg::opcode_t  o_op,
    output tenyr_pkg::deref_t   o_deref,
    output logic                o_type,
    output logic                o_is_op,
    output logic                o_is_trap
);
    import tenyr_pkg::*;

    logic is_op;

    // Two views of the same word
    assign is_op     = !i_insn.op.kind;
    assign o_is_op   = is_op;
    assign o_is_trap = (i_insn.trap.marker == TRAP_MARKER);

    // Fields read as zero for anything but an operation
    always_comb begin
        o_z     = '0;
        o_x     = '0;
        o_y     = '0;
        o_imm   = '0;
        o_op    = OP_OR;
        o_deref = DEREF_NONE;
        o_type  = 1'b0;
        if (is_op) begin
            o_z     = i_insn.op.z;
            o_x     = i_insn.op.x;
            o_y     = i_insn.op.y;
            o_imm   = i_insn.op.imm;
            o_op    = i_insn.op.op;
            o_deref = i_insn.op.deref;
            o_type  = i_insn.op.type_bit;
        end
    end

endmodule

`default_nettype wire

//--- tenyr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_regfile (
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    input  tenyr_pkg::reg_idx_t i_rd_x_idx,
    input  tenyr_pkg::reg_idx_t i_rd_y_idx,
    input  wire                 i_wr_en,
    input  tenyr_pkg::reg_idx_t i_wr_idx,
    input  tenyr_pkg::word_t    i_wr_data,
    input  tenyr_pkg::word_t    i_next_pc,
    output tenyr_pkg::word_t    o_rd_x,
    output tenyr_pkg::word_t    o_rd_y
);
    import tenyr_pkg::*;

    word_t gpr [1:14]; // General registers only

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int i = 1; i < 15; i++) begin
                gpr[i] <= '0;
            end
        end else if (i_wr_en && i_wr_idx != '0 && i_wr_idx != REG_PC) begin
            gpr[i_wr_idx] <= i_wr_data;
        end
    end

    // Index 0 is hardwired zero, index 15 shows the next instruction address
    assign o_rd_x = (i_rd_x_idx == '0)    ? '0 :
                    (i_rd_x_idx == REG_PC) ? i_next_pc : gpr[i_rd_x_idx];
    assign o_rd_y = (i_rd_y_idx == '0)    ? '0 :
                    (i_rd_y_idx == REG_PC) ? i_next_pc : gpr[i_rd_y_idx];

    // PC updates belong to the core sequencer
    a_no_pc_write: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_wr_en |-> i_wr_idx != REG_PC
    );

endmodule

`default_nettype wire

//--- tenyr_pkg.sv
`default_nettype none

package tenyr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [11:0] imm_t;

    typedef enum logic [3:0] {
        OP_OR    = 4'h0,
        OP_AND   = 4'h1,
        OP_ADD   = 4'h2,
        OP_MUL   = 4'h3,
        OP_RSVD  = 4'h4, // Yields the addend only
        OP_SHL   = 4'h5,
        OP_CMPLE = 4'h6,
        OP_CMPEQ = 4'h7,
        OP_NOR   = 4'h8,
        OP_NAND  = 4'h9,
        OP_XOR   = 4'hA,
        OP_SUB   = 4'hB,
        OP_XORN  = 4'hC, // X xor ~O
        OP_SHR   = 4'hD,
        OP_CMPGT = 4'hE,
        OP_CMPNE = 4'hF
    } opcode_t;

    typedef enum logic [1:0] {
        DEREF_NONE  = 2'b00, // Z <- rhs
        DEREF_LOAD  = 2'b01, // Z <- [rhs]
        DEREF_STZ   = 2'b10, // [Z] <- rhs
        DEREF_STRHS = 2'b11  // [rhs] <- Z
    } deref_t;

    typedef struct packed {
        logic     kind;     // Clear for an operation
        logic     type_bit; // Set swaps immediate and Y
        deref_t   deref;
        reg_idx_t z;
        reg_idx_t x;
        reg_idx_t y;
        opcode_t  op;
        imm_t     imm;
    } insn_op_t;

    typedef struct packed {
        logic [3:0]  marker;
        logic [27:0] payload;
    } insn_trap_t;

    typedef union packed {
        insn_op_t   op;
        insn_trap_t trap;
    } insn_t;

    localparam word_t      RESET_VECTOR = 32'h100;
    localparam logic [3:0] TRAP_MARKER  = 4'hF;
    localparam reg_idx_t   REG_PC       = 4'd15;

    // Core sequencer states
    localparam logic [2:0] CORE_FETCH = 3'd0;
    localparam logic [2:0] CORE_EXEC  = 3'd1;
    localparam logic [2:0] CORE_MEM   = 3'd2;
    localparam logic [2:0] CORE_WB    = 3'd3;
    localparam logic [2:0] CORE_HALT  = 3'd4;

endpackage

`default_nettype wire
